/* Makefile */
VERILATOR ?= verilator
TOP ?= tbMipiCameraConfig
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= ALL CHECKS PASSED
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sources.f */
+incdir+src
src/i2cBusPkg.sv
src/camScriptPkg.sv
src/i2cXferIf.sv
src/sensorScriptRom.sv
src/i2cMasterEngine.sv
src/camConfigCtrl.sv
src/mipiCameraConfig.sv
tb/sensorI2cModel.sv
tb/camConfig_props.sv
tb/tbMipiCameraConfig.sv

/* src/camConfigCtrl.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module camConfigCtrl (
	input  logic CLK_400K,
	input  logic RESET_N,
	i2cXferIf.ctrl xfer,
	output camScriptPkg::entryIdx_t entryIdx,
	input  camScriptPkg::scriptEntry entry,
	output i2cBusPkg::byte_t idByte,
	output logic cameraReleased
);
	camScriptPkg::cfgState state;
	logic [3:0] gapCnt;
	logic [11:0] dlyCnt;
	logic [11:0] dlyTarget;
	logic gapDone;
	logic lastEntry;

	assign gapDone = (gapCnt == 4'(`XFER_GAP - 1));
	assign dlyTarget = 12'(entry.data) * 12'(`DELAY_UNIT);   // ticks for this delay entry
	assign lastEntry = (entryIdx == camScriptPkg::entryIdx_t'(`SCRIPT_LEN - 1));

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= camScriptPkg::CFG_ID_PTR;
			xfer.start <= 1'b0;
			entryIdx <= '0;
			gapCnt <= '0;
			dlyCnt <= '0;
			idByte <= '0;
			cameraReleased <= 1'b0;
		end else begin
			xfer.start <= 1'b0;
			case (state)
				camScriptPkg::CFG_ID_PTR: if (!xfer.busy) begin
					xfer.kind <= i2cBusPkg::XFER_PTR_WRITE;
					xfer.devAddr <= `CAM_I2C_ADDR;
					xfer.regAddr <= `CAM_ID_REG;
					xfer.start <= 1'b1;
					state <= camScriptPkg::CFG_ID_PTR_WAIT;
				end
				camScriptPkg::CFG_ID_PTR_WAIT: if (xfer.done) begin
					gapCnt <= '0;
					state <= camScriptPkg::CFG_ID_GAP;
				end
				camScriptPkg::CFG_ID_GAP: begin
					gapCnt <= gapCnt + 1'b1;
					if (gapDone)
						state <= camScriptPkg::CFG_ID_READ;
				end
				camScriptPkg::CFG_ID_READ: if (!xfer.busy) begin
					xfer.kind <= i2cBusPkg::XFER_BYTE_READ;  // pointer already set
					xfer.start <= 1'b1;
					state <= camScriptPkg::CFG_ID_READ_WAIT;
				end
				camScriptPkg::CFG_ID_READ_WAIT: if (xfer.done) begin
					idByte <= xfer.rdData;
					gapCnt <= '0;
					state <= camScriptPkg::CFG_ID_CHECK;
				end
				camScriptPkg::CFG_ID_CHECK: begin
					gapCnt <= gapCnt + 1'b1;
					if (gapDone)
						state <= (idByte == `CAM_ID_EXPECTED) ? camScriptPkg::CFG_FETCH
							: camScriptPkg::CFG_ID_PTR;  // wrong ID, read again
				end
				camScriptPkg::CFG_FETCH: state <= camScriptPkg::CFG_DECODE;  // ROM latency
				camScriptPkg::CFG_DECODE: begin
					if (entry.devAddr == `SCRIPT_DELAY_MARK) begin
						dlyCnt <= '0;
						state <= camScriptPkg::CFG_DELAY;
					end else if (!xfer.busy) begin
						xfer.kind <= i2cBusPkg::XFER_BYTE_WRITE;
						xfer.devAddr <= entry.devAddr;
						xfer.regAddr <= entry.regAddr;
						xfer.wrData <= entry.data;
						xfer.start <= 1'b1;
						state <= camScriptPkg::CFG_WR_WAIT;
					end
				end
				camScriptPkg::CFG_WR_WAIT: if (xfer.done) begin
					gapCnt <= '0;
					state <= camScriptPkg::CFG_WR_GAP;
				end
				camScriptPkg::CFG_WR_GAP: begin
					gapCnt <= gapCnt + 1'b1;
					if (gapDone)
						state <= camScriptPkg::CFG_NEXT;
				end
				camScriptPkg::CFG_DELAY: begin
					dlyCnt <= dlyCnt + 1'b1;
					if (dlyCnt == dlyTarget)
						state <= camScriptPkg::CFG_NEXT;
				end
				camScriptPkg::CFG_NEXT: begin
					if (lastEntry) begin
						state <= camScriptPkg::CFG_RELEASED;
					end else begin
						entryIdx <= entryIdx + 1'b1;
						state <= camScriptPkg::CFG_FETCH;
					end
				end
				camScriptPkg::CFG_RELEASED: cameraReleased <= 1'b1;  // held until reset
				default: state <= camScriptPkg::CFG_ID_PTR;
			endcase
		end
	end

endmodule

/* src/camScriptPkg.sv */
package camScriptPkg;

	// one script line, delay entries carry the count in data
	typedef struct packed {
		i2cBusPkg::byte_t    devAddr;
		i2cBusPkg::regAddr_t regAddr;
		i2cBusPkg::byte_t    data;
	} scriptEntry;

	// controller FSM states
	typedef enum logic [3:0] {
		CFG_ID_PTR, CFG_ID_PTR_WAIT, CFG_ID_GAP,
		CFG_ID_READ, CFG_ID_READ_WAIT, CFG_ID_CHECK,
		CFG_FETCH, CFG_DECODE, CFG_WR_WAIT, CFG_WR_GAP,
		CFG_DELAY, CFG_NEXT, CFG_RELEASED
	} cfgState;

	// index into the script
	typedef logic [3:0] entryIdx_t;

endpackage

/* src/cam_consts.svh */
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// sensor addressing
`define CAM_I2C_ADDR      8'h6C     // 7-bit address in write form
`define CAM_ID_REG        16'h300B  // chip-ID register
`define CAM_ID_EXPECTED   8'h88     // ID that allows configuration

// script layout
`define SCRIPT_DELAY_MARK 8'hAA     // devAddr value of a delay entry
`define SCRIPT_LEN        10        // entries in the script
`define DELAY_UNIT        4         // ticks per delay count

// bus timing in CLK_400K ticks
`define XFER_GAP          3         // idle ticks between transfers
`define SCL_PHASES        4         // ticks per SCL bit

`endif

/* src/i2cBusPkg.sv */
package i2cBusPkg;

	// transfer kinds the engine knows
	typedef enum logic [1:0] {
		XFER_PTR_WRITE  = 2'd0,  // addr + 16-bit register pointer
		XFER_BYTE_WRITE = 2'd1,  // addr + pointer + one data byte
		XFER_BYTE_READ  = 2'd2   // addr with read bit + one byte in
	} xferKind;

	// 16-bit sensor register address
	typedef logic [15:0] regAddr_t;

	// one byte on the bus
	typedef logic [7:0] byte_t;

endpackage

/* src/i2cMasterEngine.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module i2cMasterEngine (
	input  logic CLK_400K,
	input  logic RESET_N,
	i2cXferIf.engine xfer,
	input  logic sdaIn,
	output logic sclOut,
	output logic sdaOut
);
	localparam int PH_W = $clog2(`SCL_PHASES);
	localparam logic [PH_W-1:0] PH_MID = PH_W'(`SCL_PHASES / 2);
	localparam logic [PH_W-1:0] PH_LAST = PH_W'(`SCL_PHASES - 1);

	typedef enum logic [1:0] {E_IDLE, E_START, E_BYTE, E_STOP} engState_t;

	engState_t state;
	logic [PH_W-1:0] ph;           // tick within a bit
	logic [3:0] bitCnt;            // 0..7 data, 8 ack slot
	logic [1:0] byteCnt;
	logic [1:0] lastIdx;
	logic isRead;
	logic rxSlot;                  // byte clocked in from the slave
	logic slotSda;
	i2cBusPkg::byte_t txByte;
	i2cBusPkg::byte_t rxShift;

	assign isRead = (xfer.kind == i2cBusPkg::XFER_BYTE_READ);
	assign rxSlot = isRead && (byteCnt == 2'd1);
	assign xfer.busy = (state != E_IDLE);

	always_comb begin
		case (byteCnt)
			2'd0: txByte = {xfer.devAddr[7:1], isRead};
			2'd1: txByte = xfer.regAddr[15:8];
			2'd2: txByte = xfer.regAddr[7:0];
			default: txByte = xfer.wrData;
		endcase
	end

	// bytes per transfer minus one
	always_comb begin
		case (xfer.kind)
			i2cBusPkg::XFER_PTR_WRITE: lastIdx = 2'd2;
			i2cBusPkg::XFER_BYTE_WRITE: lastIdx = 2'd3;
			default: lastIdx = 2'd1;
		endcase
	end

	// ack slots and the read byte leave SDA released, NACK on the read
	assign slotSda = (bitCnt == 4'd8 || rxSlot) ? 1'b1 : txByte[3'd7 - bitCnt[2:0]];

	always_ff @(posedge CLK_400K) begin
		if (!RESET_N) begin
			state <= E_IDLE;
			ph <= '0;
			bitCnt <= '0;
			byteCnt <= '0;
			sclOut <= 1'b1;
			sdaOut <= 1'b1;
			xfer.done <= 1'b0;
		end else begin
			xfer.done <= 1'b0;
			case (state)
				E_IDLE: begin
					sclOut <= 1'b1;
					sdaOut <= 1'b1;
					if (xfer.start) begin
						state <= E_START;
						ph <= '0;
						bitCnt <= '0;
						byteCnt <= '0;
					end
				end
				E_START: begin
					sclOut <= (ph != PH_LAST);
					sdaOut <= (ph < PH_MID);       // SDA falls while SCL high
					ph <= (ph == PH_LAST) ? '0 : ph + 1'b1;
					if (ph == PH_LAST)
						state <= E_BYTE;
				end
				E_BYTE: begin
					sclOut <= (ph != '0) && (ph != PH_LAST);
					sdaOut <= slotSda;
					if (ph == PH_MID && bitCnt < 4'd8)
						rxShift <= {rxShift[6:0], sdaIn};  // MSB first
					ph <= (ph == PH_LAST) ? '0 : ph + 1'b1;
					if (ph == PH_LAST) begin
						if (bitCnt == 4'd8) begin
							bitCnt <= '0;
							byteCnt <= byteCnt + 1'b1;
							if (byteCnt == lastIdx)
								state <= E_STOP;
						end else begin
							bitCnt <= bitCnt + 1'b1;
						end
					end
				end
				E_STOP: begin
					sclOut <= (ph != '0);
					sdaOut <= (ph >= PH_MID);      // SDA rises while SCL high
					ph <= (ph == PH_LAST) ? '0 : ph + 1'b1;
					if (ph == PH_LAST) begin
						state <= E_IDLE;
						xfer.done <= 1'b1;
						xfer.rdData <= rxShift;
					end
				end
				default: state <= E_IDLE;
			endcase
		end
	end

endmodule

/* src/i2cXferIf.sv */
`timescale 1ns/10ps

interface i2cXferIf;
	logic                start;    // one-tick request pulse
	i2cBusPkg::xferKind  kind;
	i2cBusPkg::byte_t    devAddr;  // write-form slave address
	i2cBusPkg::regAddr_t regAddr;
	i2cBusPkg::byte_t    wrData;
	logic                busy;     // engine holds a transfer
	logic                done;     // one-tick end pulse
	i2cBusPkg::byte_t    rdData;   // valid with done

	modport ctrl (output start, kind, devAddr, regAddr, wrData,
		input busy, done, rdData);

	modport engine (input start, kind, devAddr, regAddr, wrData,
		output busy, done, rdData);

endinterface

/* src/mipiCameraConfig.sv */
`timescale 1ns/10ps

module mipiCameraConfig (
	input  logic CLK_400K,
	input  logic RESET_N,
	output logic i2cScl,
	inout  wire  i2cSda,
	output logic [7:0] idByte,
	output logic cameraReleased
);
	camScriptPkg::entryIdx_t entryIdx;
	camScriptPkg::scriptEntry entry;
	logic sclOut;
	logic sdaOut;

	i2cXferIf xferBus ();

	camConfigCtrl ctrl_i (
		.CLK_400K       (CLK_400K),
		.RESET_N        (RESET_N),
		.xfer           (xferBus.ctrl),
		.entryIdx       (entryIdx),
		.entry          (entry),
		.idByte         (idByte),
		.cameraReleased (cameraReleased)
	);

	i2cMasterEngine engine_i (
		.CLK_400K (CLK_400K),
		.RESET_N  (RESET_N),
		.xfer     (xferBus.engine),
		.sdaIn    (i2cSda),
		.sclOut   (sclOut),
		.sdaOut   (sdaOut)
	);

	sensorScriptRom rom_i (
		.CLK_400K (CLK_400K),
		.entryIdx (entryIdx),
		.entry    (entry)
	);

	assign i2cSda = sdaOut ? 1'bz : 1'b0;  // open drain, pulled up on the board
	assign i2cScl = sclOut ? 1'b1 : 1'b0;

endmodule

/* src/sensorScriptRom.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module sensorScriptRom (
	input  logic CLK_400K,
	input  camScriptPkg::entryIdx_t entryIdx,
	output camScriptPkg::scriptEntry entry
);

	// devAddr, register, data
	always_ff @(posedge CLK_400K) begin
		case (entryIdx)
			4'd0: entry <= {`CAM_I2C_ADDR, 16'h0103, 8'h01};       // software reset
			4'd1: entry <= {`SCRIPT_DELAY_MARK, 16'h0000, 8'd10};  // settle after reset
			4'd2: entry <= {`CAM_I2C_ADDR, 16'h0100, 8'h00};       // standby
			4'd3: entry <= {`CAM_I2C_ADDR, 16'h0302, 8'd24};       // pll1 multiplier
			4'd4: entry <= {`CAM_I2C_ADDR, 16'h0304, 8'd3};        // pll1 mipi divider
			4'd5: entry <= {`CAM_I2C_ADDR, 16'h3808, 8'h02};       // x size high
			4'd6: entry <= {`CAM_I2C_ADDR, 16'h3809, 8'h80};       // x size low
			4'd7: entry <= {`CAM_I2C_ADDR, 16'h380A, 8'h01};       // y size high
			4'd8: entry <= {`SCRIPT_DELAY_MARK, 16'h0000, 8'd6};
			4'd9: entry <= {`CAM_I2C_ADDR, 16'h0100, 8'h01};       // wake up, streaming
			default: entry <= '0;
		endcase
	end

endmodule

/* tb/camConfig_props.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module camConfig_props (
	input logic CLK_400K,
	input logic RESET_N,
	input logic i2cScl,
	input logic i2cSda,
	input logic [7:0] idByte,
	input logic cameraReleased
);
	int resetFails = 0;
	int protoFails = 0;
	int releaseFails = 0;

	// pads released and no release level while in reset
	assert property (@(posedge CLK_400K) !RESET_N |=> (i2cScl && i2cSda && !cameraReleased))
		else begin
			$error("bus not idle or release high around reset");
			resetFails++;
		end

	// SDA falls with SCL high only at a START after a long SCL high
	assert property (@(posedge CLK_400K) disable iff (!RESET_N)
		($fell(i2cSda) && i2cScl) |-> ($past(i2cScl) && $past(i2cScl, 2)))
		else begin
			$error("SDA fell with SCL high outside a START");
			protoFails++;
		end

	// SDA rises with SCL high only at a STOP and the bus stays idle
	assert property (@(posedge CLK_400K) disable iff (!RESET_N)
		($rose(i2cSda) && i2cScl) |=> (i2cScl && i2cSda) [*2])
		else begin
			$error("SDA rose with SCL high outside a STOP");
			protoFails++;
		end

	assert property (@(posedge CLK_400K) disable iff (!RESET_N)
		cameraReleased |-> (idByte == `CAM_ID_EXPECTED && i2cScl && i2cSda))
		else begin
			$error("released with wrong ID or busy bus");
			releaseFails++;
		end

	assert property (@(posedge CLK_400K) disable iff (!RESET_N)
		cameraReleased |=> cameraReleased)
		else begin
			$error("release level dropped");
			releaseFails++;
		end

endmodule

/* tb/sensorI2cModel.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module sensorI2cModel (
	input  logic scl,
	inout  wire  sda,
	input  int   wrongIds
);
	localparam logic [7:0] DEV_W = `CAM_I2C_ADDR;
	localparam logic [7:0] WRONG_ID = 8'h47;   // answer before the sensor is ready

	logic sdaDrive = 1'b1;      // 0 pulls SDA low
	logic active = 1'b0;
	logic addressed = 1'b0;
	logic isRd = 1'b0;
	logic sending = 1'b0;       // slave shifts the ID out
	logic idMatched = 1'b0;
	int bitPos = 0;
	int byteIdx = 0;
	logic [7:0] shiftReg;
	logic [7:0] txByte;
	logic [7:0] rxBytes [4];
	logic [15:0] ptr = '0;
	time startTime = 0;
	time lastIdStop = 0;
	int wrCount = 0;
	int idReads = 0;
	int earlyWrites = 0;        // writes seen before a good ID
	logic [15:0] wrReg [16];
	logic [7:0] wrData [16];
	time wrStart [16];
	time wrStop [16];

	assign sda = sdaDrive ? 1'bz : 1'b0;

	// START
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active = 1'b1;
			bitPos = 0;
			byteIdx = 0;
			sending = 1'b0;
			addressed = 1'b0;
			isRd = 1'b0;
			startTime = $time;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			if (bitPos < 8)
				shiftReg = {shiftReg[6:0], sda};
			bitPos = bitPos + 1;
		end
	end

	// slave changes SDA only while SCL is low
	always @(negedge scl) begin
		if (active) begin
			if (bitPos == 8) begin
				if (sending) begin
					sdaDrive = 1'b1;       // master NACKs
				end else begin
					if (byteIdx == 0) begin
						addressed = (shiftReg[7:1] == DEV_W[7:1]);
						isRd = shiftReg[0];
					end
					if (byteIdx < 4)
						rxBytes[byteIdx] = shiftReg;
					sdaDrive = !addressed;  // ack
				end
			end else if (bitPos == 9) begin
				byteIdx = byteIdx + 1;
				bitPos = 0;
				sdaDrive = 1'b1;
				sending = addressed && isRd && (byteIdx == 1);
				if (sending) begin
					txByte = (idReads < wrongIds) ? WRONG_ID : `CAM_ID_EXPECTED;
					sdaDrive = txByte[7];
				end
			end else if (sending && bitPos > 0 && bitPos < 8) begin
				sdaDrive = txByte[7 - bitPos];
			end
		end
	end

	// STOP closes the transfer and logs it
	always @(posedge sda) begin
		if (scl === 1'b1 && active) begin
			active = 1'b0;
			sdaDrive = 1'b1;
			if (addressed && !isRd && byteIdx == 3) begin
				ptr = {rxBytes[1], rxBytes[2]};
			end else if (addressed && !isRd && byteIdx == 4) begin
				wrReg[wrCount] = {rxBytes[1], rxBytes[2]};
				wrData[wrCount] = rxBytes[3];
				wrStart[wrCount] = startTime;
				wrStop[wrCount] = $time;
				wrCount = wrCount + 1;
				if (!idMatched)
					earlyWrites = earlyWrites + 1;
			end else if (addressed && isRd && byteIdx == 2 && ptr == `CAM_ID_REG) begin
				idReads = idReads + 1;
				lastIdStop = $time;
				if (idReads > wrongIds)
					idMatched = 1'b1;
			end
		end
	end

endmodule

/* tb/tbMipiCameraConfig.sv */
`timescale 1ns/10ps
`include "cam_consts.svh"

module tbMipiCameraConfig;
	localparam int TICK_NS = 8;
	localparam int XFER4_TICKS = (4 * 9 + 2) * `SCL_PHASES;  // START, 4 bytes with ack, STOP
	localparam int DELAY_TICKS = (10 + 6) * `DELAY_UNIT;
	localparam int WATCHDOG_NS = (2 * (`SCRIPT_LEN + 4) * XFER4_TICKS + DELAY_TICKS) * TICK_NS;
	localparam int N_WRITES = 8;

	logic CLK_400K;
	logic RESET_N;
	logic i2cScl;
	wire i2cSda;
	logic [7:0] idByte;
	logic cameraReleased;
	int wrongIds;
	int bad;
	int testsOk;
	int testsBad;
	int writesAtRelease;
	time releaseTime;
	logic [15:0] expReg [N_WRITES];
	logic [7:0] expData [N_WRITES];
	int dlyAfter [2];            // write index before each delay entry
	int dlyCount [2];

	pullup (i2cSda);

	mipiCameraConfig dut_i (
		.CLK_400K       (CLK_400K),
		.RESET_N        (RESET_N),
		.i2cScl         (i2cScl),
		.i2cSda         (i2cSda),
		.idByte         (idByte),
		.cameraReleased (cameraReleased)
	);

	sensorI2cModel model_i (
		.scl      (i2cScl),
		.sda      (i2cSda),
		.wrongIds (wrongIds)
	);

	bind mipiCameraConfig camConfig_props props_i (
		.CLK_400K       (CLK_400K),
		.RESET_N        (RESET_N),
		.i2cScl         (i2cScl),
		.i2cSda         (i2cSda),
		.idByte         (idByte),
		.cameraReleased (cameraReleased)
	);

	task automatic loadExpected();
		expReg[0] = 16'h0103;
		expData[0] = 8'h01;
		expReg[1] = 16'h0100;
		expData[1] = 8'h00;
		expReg[2] = 16'h0302;
		expData[2] = 8'h18;
		expReg[3] = 16'h0304;
		expData[3] = 8'h03;
		expReg[4] = 16'h3808;
		expData[4] = 8'h02;
		expReg[5] = 16'h3809;
		expData[5] = 8'h80;
		expReg[6] = 16'h380A;
		expData[6] = 8'h01;
		expReg[7] = 16'h0100;
		expData[7] = 8'h01;
		dlyAfter[0] = 0;
		dlyCount[0] = 10;
		dlyAfter[1] = 6;
		dlyCount[1] = 6;
	endtask

	task automatic expectEq(input longint got, input longint exp, input string what);
		assert (got == exp) else begin
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
			bad++;
		end
	endtask

	task automatic expectTrue(input bit cond, input string what);
		assert (cond) else begin
			$display("[FAIL] %0t %s", $time, what);
			bad++;
		end
	endtask

	task automatic finishTest(input string name);
		if (bad == 0) begin
			$display("test %s: ok", name);
			testsOk++;
		end else begin
			$display("test %s: %0d errors", name, bad);
			testsBad++;
		end
		bad = 0;
	endtask

	initial begin
		CLK_400K = 1'b0;
		forever #(TICK_NS / 2) CLK_400K = ~CLK_400K;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: camera not released after %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		RESET_N = 1'b0;
		bad = 0;
		testsOk = 0;
		testsBad = 0;
		void'($urandom(51));
		wrongIds = 1 + int'($urandom % 3);    // 1 to 3 bad answers
		loadExpected();
		repeat (3) @(posedge CLK_400K);
		#1 RESET_N = 1'b1;

		wait (cameraReleased === 1'b1);
		releaseTime = $time;
		writesAtRelease = model_i.wrCount;
		repeat (20) @(posedge CLK_400K);      // let release asserts watch the idle bus

		expectEq(dut_i.props_i.resetFails, 0, "reset idle assertion failures");
		finishTest("reset idle");

		expectEq(dut_i.props_i.protoFails, 0, "bus protocol assertion failures");
		finishTest("bus protocol");

		expectEq(model_i.idReads, wrongIds + 1, "ID reads");
		expectEq(model_i.earlyWrites, 0, "writes before matching ID");
		expectEq(idByte, `CAM_ID_EXPECTED, "idByte");
		expectTrue(model_i.wrStart[0] > model_i.lastIdStop,
			"a script write started before the matching ID read ended");
		finishTest("ID retry");

		expectEq(model_i.wrCount, N_WRITES, "write count");
		for (int i = 0; i < N_WRITES; i++) begin
			expectEq(model_i.wrReg[i], expReg[i], $sformatf("write %0d register", i));
			expectEq(model_i.wrData[i], expData[i], $sformatf("write %0d data", i));
		end
		finishTest("script order");

		for (int d = 0; d < 2; d++) begin
			expectTrue(model_i.wrStart[dlyAfter[d] + 1] - model_i.wrStop[dlyAfter[d]]
				>= time'(dlyCount[d] * `DELAY_UNIT * TICK_NS),
				$sformatf("bus gap across delay %0d too short", d));
		end
		finishTest("delays");

		expectEq(writesAtRelease, N_WRITES, "writes logged at release");
		expectTrue(releaseTime > model_i.wrStop[N_WRITES - 1],
			"release rose before the wake-up write ended");
		expectTrue(cameraReleased === 1'b1, "release level not held");
		expectEq(dut_i.props_i.releaseFails, 0, "release assertion failures");
		finishTest("release");

		$display("tests passed: %0d, failed: %0d", testsOk, testsBad);
		if (testsBad == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
